// File: buffer_pkg.sv
`default_nettype none

package buffer_pkg;

    // one of the four line slots
    typedef logic [1:0] slot_t;

    // {slot, column[9:0]}
    typedef logic [11:0] buf_addr_t;

    // reader FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_STREAM,
        RD_RELEASE
    } reader_state_e;

endpackage

`default_nettype wire

// File: capture_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_capture_config.svh"

module capture_window (
    input  wire                           clock,
    input  wire                           arst_n,
    input  wire video_pkg::pixel_t        pixel,
    input  wire video_pkg::raster_count_t counter_x,
    input  wire video_pkg::raster_count_t counter_y,
    input  wire video_pkg::capture_mode_e mode,
    input  wire                           slot_credit,
    output logic                          wr_en,
    output buffer_pkg::buf_addr_t         wr_addr,
    output video_pkg::pixel_t             wr_data,
    output logic                          line_written,
    output logic                          line_dropped,
    output logic                          start_trigger
);

    video_pkg::raster_count_t h_start;
    video_pkg::raster_count_t trig_y;
    video_pkg::raster_count_t column;
    logic                     v_active;
    logic                     h_active;
    logic                     active;
    logic                     first_col;
    logic                     last_col;
    logic                     has_free;
    logic                     spend;
    logic [2:0]               free_slots;
    buffer_pkg::slot_t        wr_slot;
    logic                     line_keep;

    // ============================================================
    // window decode
    // ============================================================

    always_comb begin
        if (mode == video_pkg::MODE_DOUBLED) begin
            h_start  = 12'(`LC_H_START_D);
            trig_y   = 12'(`LC_TRIG_Y_D);
            v_active = (counter_y < 12'(`LC_V_FIELD1_END)) ||
                       ((counter_y >= 12'(`LC_V_FIELD2_START)) &&
                        (counter_y < 12'(`LC_V_FIELD2_END)));
        end else begin
            h_start  = 12'(`LC_H_START_P);
            trig_y   = 12'(`LC_TRIG_Y_P);
            v_active = counter_y < 12'(`LC_V_END_P);
        end
    end

    assign column    = counter_x - h_start;
    assign h_active  = (counter_x >= h_start) && (column < 12'(`LC_LINE_WIDTH));
    assign active    = h_active && v_active;
    assign first_col = active && (column == 12'd0);
    assign last_col  = active && (column == 12'(`LC_LINE_WIDTH - 1));

    // keep/drop is decided once, at column 0
    assign has_free  = free_slots != 3'd0;
    assign spend     = first_col && has_free;

    // ============================================================
    // slot accounting and write control
    // ============================================================

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            free_slots    <= 3'(`LC_SLOTS);
            wr_slot       <= '0;
            line_keep     <= 1'b0;
            wr_en         <= 1'b0;
            line_written  <= 1'b0;
            line_dropped  <= 1'b0;
            start_trigger <= 1'b0;
        end else begin
            case ({spend, slot_credit})
                2'b10:   free_slots <= free_slots - 3'd1;
                2'b01:   free_slots <= free_slots + 3'd1;
                default: free_slots <= free_slots;
            endcase

            if (first_col) begin
                line_keep <= has_free;
            end else if (last_col) begin
                line_keep <= 1'b0;
            end

            wr_en        <= first_col ? has_free : (active && line_keep);
            line_dropped <= first_col && !has_free;
            line_written <= last_col && line_keep;

            // next kept line goes to the next slot
            if (last_col && line_keep) begin
                wr_slot <= wr_slot + 2'd1;
            end

            start_trigger <= (counter_x == 12'(`LC_TRIG_X)) && (counter_y == trig_y);
        end
    end

    // write payload, one cycle behind the counters
    always_ff @(posedge clock) begin
        wr_addr <= {wr_slot, column[9:0]};
        wr_data <= pixel;
    end

endmodule

`default_nettype wire

// File: line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_capture_config.svh"

module line_buffer (
    input  wire                        clock,
    input  wire                        wr_en,
    input  wire buffer_pkg::buf_addr_t wr_addr,
    input  wire video_pkg::pixel_t     wr_data,
    input  wire                        rd_en,
    input  wire buffer_pkg::buf_addr_t rd_addr,
    output video_pkg::pixel_t          rd_data
);

    localparam int DEPTH = `LC_SLOTS * 1024;

    // one 1024-word region per slot
    video_pkg::pixel_t mem [0:DEPTH-1];

    // ============================================================
    // write port
    // ============================================================

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ============================================================
    // read port, registered
    // ============================================================

    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: line_capture.f
+incdir+.
video_pkg.sv
buffer_pkg.sv
capture_window.sv
line_buffer.sv
line_reader.sv
line_capture_top.sv
line_capture_chk.sv
line_capture_tb.sv

// File: line_capture_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_capture_config.svh"

module line_capture_chk (
    input wire clock,
    input wire arst_n,
    input wire out_credit,
    input wire out_valid,
    input wire start_trigger,
    input wire line_written,
    input wire slot_credit
);

    logic [31:0] granted;
    logic [31:0] delivered;
    logic [2:0]  lines_held;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            granted    <= '0;
            delivered  <= '0;
            lines_held <= '0;
        end else begin
            if (out_credit) begin
                granted <= granted + 32'd1;
            end
            if (out_valid) begin
                delivered <= delivered + 32'd1;
            end
            case ({line_written, slot_credit})
                2'b10:   lines_held <= lines_held + 3'd1;
                2'b01:   lines_held <= lines_held - 3'd1;
                default: lines_held <= lines_held;
            endcase
        end
    end

    // every pixel out is backed by a credit from an earlier cycle
    credit_before_valid: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid |-> (delivered < granted))
        else $error("out_valid without an earlier out_credit");

    trigger_single: assert property (@(posedge clock) disable iff (!arst_n)
        start_trigger |=> !start_trigger)
        else $error("start_trigger high on two cycles in a row");

    lines_bounded: assert property (@(posedge clock) disable iff (!arst_n)
        lines_held <= 3'(`LC_SLOTS))
        else $error("more lines held than line slots");

endmodule

bind line_capture_top line_capture_chk u_chk (
    .clock         (clock),
    .arst_n        (arst_n),
    .out_credit    (out_credit),
    .out_valid     (out_valid),
    .start_trigger (start_trigger),
    .line_written  (line_written),
    .slot_credit   (slot_credit)
);

`default_nettype wire

// File: line_capture_config.svh
`ifndef LINE_CAPTURE_CONFIG_SVH
`define LINE_CAPTURE_CONFIG_SVH

// ============================================================
// line buffer geometry
// ============================================================

`define LC_LINE_WIDTH 640
`define LC_SLOTS 4

// most pixel credits the reader can bank
`define LC_OUT_CREDITS 8

// ============================================================
// capture window
// ============================================================

// first captured column per mode
`define LC_H_START_P 44
`define LC_H_START_D 1

// 480p rows
`define LC_V_END_P 480

// doubled mode, two fields
`define LC_V_FIELD1_END 240
`define LC_V_FIELD2_START 263
`define LC_V_FIELD2_END 504

// start trigger point, row per mode
`define LC_TRIG_X 320
`define LC_TRIG_Y_P 0
`define LC_TRIG_Y_D 1

`endif

// File: line_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_capture_config.svh"

module line_capture_tb;

    localparam int H_TOTAL      = 800;
    localparam int V_TOTAL      = 525;
    localparam int FRAMES       = 4;
    localparam int CLOCK_PERIOD = 40;
    localparam longint WATCHDOG_NS =
        longint'(FRAMES * H_TOTAL * V_TOTAL + H_TOTAL * V_TOTAL / 2) * CLOCK_PERIOD;

    logic                     clock;
    logic                     arst_n;
    video_pkg::pixel_t        pixel;
    video_pkg::raster_count_t counter_x;
    video_pkg::raster_count_t counter_y;
    video_pkg::capture_mode_e mode;
    logic                     out_credit;
    video_pkg::pixel_t        out_data;
    logic                     out_valid;
    logic                     start_trigger;
    logic                     line_dropped;

    integer seed;
    int     errors;
    int     frame;

    // reference model
    video_pkg::pixel_t expect_q[$];
    int                free_slots = `LC_SLOTS;
    int                bank       = 0;
    bit                credit_d1  = 1'b0;
    bit                credit_d2  = 1'b0;
    int                delivered  = 0;
    longint            granted    = 0;
    bit                keep_line  = 1'b0;
    bit                trig_exp   = 1'b0;
    bit                drop_exp   = 1'b0;
    int                outs  [0:FRAMES] = '{default: 0};
    int                drops [0:FRAMES] = '{default: 0};
    int                trigs [0:FRAMES] = '{default: 0};

    line_capture_top UUT (
        .clock         (clock),
        .arst_n        (arst_n),
        .pixel         (pixel),
        .counter_x     (counter_x),
        .counter_y     (counter_y),
        .mode          (mode),
        .out_credit    (out_credit),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .start_trigger (start_trigger),
        .line_dropped  (line_dropped)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic video_pkg::capture_mode_e frame_mode(input int f);
        if (f % 2 == 1) begin
            return video_pkg::MODE_DOUBLED;
        end
        return video_pkg::MODE_480P;
    endfunction

    // frame 3 runs short of credits (odds in eighths)
    function automatic int credit_odds(input int f);
        return (f == 3) ? 4 : 7;
    endfunction

    task automatic value_mismatch(input string name, input logic [23:0] expected,
                                  input logic [23:0] actual);
        errors++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic count_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic plain_failure(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // ============================================================
    // raster source and credit sink
    // ============================================================

    always @(posedge clock) begin : raster
        if (arst_n) begin
            pixel <= video_pkg::pixel_t'($random(seed));
            if (frame == 2 && int'(counter_y) < `LC_V_END_P) begin
                out_credit <= 1'b0;
            end else begin
                out_credit <= ($random(seed) & 7) < credit_odds(frame);
            end
            if (frame < FRAMES) begin
                if (int'(counter_x) != H_TOTAL - 1) begin
                    counter_x <= counter_x + 12'd1;
                end else if (int'(counter_y) != V_TOTAL - 1) begin
                    counter_x <= '0;
                    counter_y <= counter_y + 12'd1;
                end else begin
                    // after the last frame the raster parks in blanking
                    counter_x <= '0;
                    frame     <= frame + 1;
                    if (frame != FRAMES - 1) begin
                        counter_y <= '0;
                        mode      <= frame_mode(frame + 1);
                    end
                end
            end
        end
    end

    // ============================================================
    // reference model and checks
    // ============================================================

    always @(posedge clock) begin : model
        int                x;
        int                y;
        int                h_start;
        bit                v_act;
        bit                active;
        video_pkg::pixel_t expected;
        if (arst_n) begin
            assert (start_trigger == trig_exp)
            else value_mismatch("start_trigger", 24'(trig_exp), 24'(start_trigger));
            assert (line_dropped == drop_exp)
            else value_mismatch("line_dropped", 24'(drop_exp), 24'(line_dropped));
            if (start_trigger) trigs[frame]++;
            if (line_dropped) drops[frame]++;
            if (out_credit) granted++;
            // reader credits as they stood when this pixel's read was issued
            if (out_valid) begin
                assert (bank > 0) else plain_failure("out_valid with no pixel credit banked");
            end
            if (credit_d2 && !out_valid) begin
                if (bank < `LC_OUT_CREDITS) bank++;
            end else if (!credit_d2 && out_valid && bank > 0) begin
                bank--;
            end
            credit_d2 = credit_d1;
            credit_d1 = out_credit;
            // output side first so a slot freed here serves this edge's capture
            if (out_valid) begin
                delivered++;
                outs[frame]++;
                assert (expect_q.size() != 0)
                else plain_failure("out_valid with no captured pixel pending");
                if (expect_q.size() != 0) begin
                    expected = expect_q.pop_front();
                    assert (out_data == expected)
                    else value_mismatch("out_data", expected, out_data);
                end
                if (delivered % `LC_LINE_WIDTH == 0) free_slots++;
            end
            x = int'(counter_x);
            y = int'(counter_y);
            if (mode == video_pkg::MODE_DOUBLED) begin
                h_start  = `LC_H_START_D;
                v_act    = (y < `LC_V_FIELD1_END) ||
                           (y >= `LC_V_FIELD2_START && y < `LC_V_FIELD2_END);
                trig_exp = (x == `LC_TRIG_X) && (y == `LC_TRIG_Y_D);
            end else begin
                h_start  = `LC_H_START_P;
                v_act    = y < `LC_V_END_P;
                trig_exp = (x == `LC_TRIG_X) && (y == `LC_TRIG_Y_P);
            end
            active   = v_act && x >= h_start && x < h_start + `LC_LINE_WIDTH;
            drop_exp = 1'b0;
            if (active && x == h_start) begin
                keep_line = free_slots > 0;
                drop_exp  = !keep_line;
                if (keep_line) free_slots--;
            end
            if (active && keep_line) expect_q.push_back(pixel);
        end
    end

    initial begin : main
        int f;
        seed       = 32'h6a3aca5f;
        errors     = 0;
        frame      = 0;
        arst_n     = 1'b0;
        pixel      = '0;
        counter_x  = '0;
        counter_y  = '0;
        mode       = video_pkg::MODE_480P;
        out_credit = 1'b0;
        repeat (8) @(posedge clock);
        arst_n <= 1'b1;
        wait (frame == FRAMES);
        while (expect_q.size() != 0) @(posedge clock);
        repeat (16) @(posedge clock);

        assert (drops[0] == 0) else count_mismatch("line_dropped pulses, 480p", 0, drops[0]);
        assert (drops[1] == 0) else count_mismatch("line_dropped pulses, doubled", 0, drops[1]);
        assert (outs[0] == `LC_V_END_P * `LC_LINE_WIDTH)
        else count_mismatch("out_valid pixels, 480p", `LC_V_END_P * `LC_LINE_WIDTH, outs[0]);
        assert (outs[1] == 481 * `LC_LINE_WIDTH)
        else count_mismatch("out_valid pixels, doubled", 481 * `LC_LINE_WIDTH, outs[1]);
        // stall frame keeps only its first four lines
        assert (drops[2] == `LC_V_END_P - `LC_SLOTS)
        else count_mismatch("line_dropped pulses, stall", `LC_V_END_P - `LC_SLOTS, drops[2]);
        assert (outs[2] == `LC_SLOTS * `LC_LINE_WIDTH)
        else count_mismatch("out_valid pixels, stall", `LC_SLOTS * `LC_LINE_WIDTH, outs[2]);
        for (f = 0; f < FRAMES; f++) begin
            assert (trigs[f] == 1) else count_mismatch("start_trigger pulses", 1, trigs[f]);
        end
        assert (longint'(delivered) <= granted)
        else plain_failure("more pixels delivered than credits granted");

        $display("errors: %0d, pixels delivered: %0d, credits granted: %0d",
                 errors, delivered, granted);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired before the output stream drained");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: line_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module line_capture_top (
    input  wire                           clock,
    input  wire                           arst_n,
    input  wire video_pkg::pixel_t        pixel,
    input  wire video_pkg::raster_count_t counter_x,
    input  wire video_pkg::raster_count_t counter_y,
    input  wire video_pkg::capture_mode_e mode,
    input  wire                           out_credit,
    output video_pkg::pixel_t             out_data,
    output logic                          out_valid,
    output logic                          start_trigger,
    output logic                          line_dropped
);

    // ============================================================
    // buffer write side
    // ============================================================

    logic                  wr_en;
    buffer_pkg::buf_addr_t wr_addr;
    video_pkg::pixel_t     wr_data;
    logic                  line_written;

    // ============================================================
    // buffer read side and slot return
    // ============================================================

    logic                  rd_en;
    buffer_pkg::buf_addr_t rd_addr;
    video_pkg::pixel_t     rd_data;
    logic                  slot_credit;

    capture_window u_capture (
        .clock         (clock),
        .arst_n        (arst_n),
        .pixel         (pixel),
        .counter_x     (counter_x),
        .counter_y     (counter_y),
        .mode          (mode),
        .slot_credit   (slot_credit),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .line_written  (line_written),
        .line_dropped  (line_dropped),
        .start_trigger (start_trigger)
    );

    line_buffer u_buffer (
        .clock   (clock),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    line_reader u_reader (
        .clock        (clock),
        .arst_n       (arst_n),
        .line_written (line_written),
        .out_credit   (out_credit),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .slot_credit  (slot_credit),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .rd_data      (rd_data)
    );

endmodule

`default_nettype wire

// File: line_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "line_capture_config.svh"

module line_reader (
    input  wire                    clock,
    input  wire                    arst_n,
    input  wire                    line_written,
    input  wire                    out_credit,
    output logic                   rd_en,
    output buffer_pkg::buf_addr_t  rd_addr,
    output logic                   slot_credit,
    output video_pkg::pixel_t      out_data,
    output logic                   out_valid,
    input  wire video_pkg::pixel_t rd_data
);

    buffer_pkg::reader_state_e state;
    logic [2:0]                pending;
    logic [3:0]                credits;
    logic [9:0]                col;
    buffer_pkg::slot_t         rd_slot;
    logic                      take_line;
    logic                      issue;
    logic                      last_read;

    assign take_line = (state == buffer_pkg::RD_IDLE) && (pending != 3'd0);
    assign issue     = (state == buffer_pkg::RD_STREAM) && (credits != 4'd0);
    assign last_read = issue && (col == 10'(`LC_LINE_WIDTH - 1));

    // lines in the same cycle as the last rd_en of a line
    assign slot_credit = state == buffer_pkg::RD_RELEASE;

    // buffer output is already registered
    assign out_data = rd_data;

    // ============================================================
    // line and pixel credit counters
    // ============================================================

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
            credits <= '0;
        end else begin
            case ({line_written, take_line})
                2'b10:   pending <= pending + 3'd1;
                2'b01:   pending <= pending - 3'd1;
                default: pending <= pending;
            endcase

            // saturate at the credit limit
            case ({out_credit, issue})
                2'b10: begin
                    if (credits != 4'(`LC_OUT_CREDITS)) begin
                        credits <= credits + 4'd1;
                    end
                end
                2'b01:   credits <= credits - 4'd1;
                default: credits <= credits;
            endcase
        end
    end

    // ============================================================
    // reader FSM
    // ============================================================

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= buffer_pkg::RD_IDLE;
            col       <= '0;
            rd_slot   <= '0;
            rd_en     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            rd_en     <= issue;
            out_valid <= rd_en;

            case (state)
                buffer_pkg::RD_IDLE: begin
                    if (take_line) begin
                        col   <= '0;
                        state <= buffer_pkg::RD_STREAM;
                    end
                end
                buffer_pkg::RD_STREAM: begin
                    // stalls here without credits, col held
                    if (issue) begin
                        col <= col + 10'd1;
                    end
                    if (last_read) begin
                        state <= buffer_pkg::RD_RELEASE;
                    end
                end
                buffer_pkg::RD_RELEASE: begin
                    rd_slot <= rd_slot + 2'd1;
                    state   <= buffer_pkg::RD_IDLE;
                end
                default: state <= buffer_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        rd_addr <= {rd_slot, col};
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the line capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module line_capture_tb \
    -Mdir obj_dir -o line_capture_sim \
    -f line_capture.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/line_capture_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: video_pkg.sv
`default_nettype none

package video_pkg;

    // source timing, picks the capture window
    typedef enum logic {
        MODE_480P,
        MODE_DOUBLED
    } capture_mode_e;

    // R in [23:16], G in [15:8], B in [7:0]
    typedef logic [23:0] pixel_t;

    // source raster counters
    typedef logic [11:0] raster_count_t;

endpackage

`default_nettype wire
